//--- verilog/stopwatch_pkg.sv
package stopwatch_pkg;

  // ======================================================================
  // Timing
  // ======================================================================

  // Largest value of one decimal digit
  localparam int DIGIT_MAX = 9;

  // Running cycles per hundredth of a second
  localparam int TICK_DIVIDE = 3;

  // Prescaler width, never narrower than one bit
  localparam int TICK_CNT_W = (TICK_DIVIDE > 1) ? $clog2(TICK_DIVIDE) : 1;

  // ======================================================================
  // Time value
  // ======================================================================

  typedef logic [3:0] digit_t;

  // 0 is hundredths, 3 is tens of seconds
  typedef logic [1:0] digit_sel_t;

  typedef logic [TICK_CNT_W-1:0] tick_cnt_t;

  typedef struct packed {
    digit_t ten_sec;
    digit_t sec;
    digit_t tenth;
    digit_t hundredth;
  } time_t;

  // One-cycle request to bump a single digit
  typedef struct packed {
    logic       inc;
    digit_sel_t sel;
  } edit_cmd_t;

  // Operating modes of the control FSM
  typedef enum logic [2:0] {
    IDLE,
    EDIT_HUND,
    EDIT_TENTH,
    EDIT_SEC,
    EDIT_TENSEC,
    RUN
  } mode_e;

endpackage

//--- verilog/panel_pkg.sv
package panel_pkg;

  // ======================================================================
  // Button conditioning
  // ======================================================================

  // Flops between the pad and the filter
  localparam int SYNC_STAGES = 2;

  // Cycles a new level must hold before it is accepted
  localparam int DEBOUNCE_CYCLES = 4;

  localparam int DEBOUNCE_CNT_W =
      (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

  typedef logic [DEBOUNCE_CNT_W-1:0] debounce_cnt_t;

  // Press events, each high for one cycle only
  typedef struct packed {
    logic start_stop;
    logic set;
    logic change;
  } buttons_t;

  // ======================================================================
  // Display
  // ======================================================================

  // Segment order gfedcba, a zero lights the segment
  typedef logic [6:0] seg_t;

  // hex3 is the leftmost display
  typedef struct packed {
    seg_t hex3;
    seg_t hex2;
    seg_t hex1;
    seg_t hex0;
  } display_t;

endpackage

//--- verilog/button_debouncer.sv
`timescale 1ns/10ps

module button_debouncer
  import panel_pkg::*;
(
  input  logic clk100_i,
  input  logic rstn_i,
  input  logic button_i,
  output logic pressed_o
);

  logic [SYNC_STAGES-1:0] sync_q;
  logic                   sync_level;
  logic                   stable_q;
  debounce_cnt_t          cnt_q;
  logic                   accept;
  logic                   pressed_q;

  // Synchroniser, released level is high
  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], button_i};
    end
  end

  assign sync_level = sync_q[SYNC_STAGES-1];

  // New level seen on DEBOUNCE_CYCLES cycles in a row
  assign accept = (sync_level != stable_q) &&
                  (cnt_q == debounce_cnt_t'(DEBOUNCE_CYCLES - 1));

  // Stability counter, restarts whenever the level falls back
  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cnt_q    <= '0;
      stable_q <= 1'b1;
    end else if (sync_level == stable_q || accept) begin
      cnt_q    <= '0;
      stable_q <= sync_level;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Press pulse on the accepted high-to-low change
  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      pressed_q <= 1'b0;
    end else begin
      pressed_q <= accept && !sync_level;
    end
  end

  assign pressed_o = pressed_q;

  // A press is an event, never a level
  a_single_pulse : assert property (
    @(posedge clk100_i) disable iff (!rstn_i)
    pressed_o |=> !pressed_o
  );

endmodule

//--- verilog/stopwatch_control.sv
`timescale 1ns/10ps

module stopwatch_control
  import stopwatch_pkg::*, panel_pkg::*;
(
  input  logic      clk100_i,
  input  logic      rstn_i,
  input  buttons_t  buttons_i,
  output logic      running_o,
  output edit_cmd_t edit_o
);

  mode_e     mode_q;
  mode_e     mode_d;
  logic      running_q;
  edit_cmd_t edit_q;
  edit_cmd_t edit_d;

  // Digit owned by each edit mode
  function automatic digit_sel_t mode_digit(mode_e mode);
    digit_sel_t sel;
    case (mode)
      EDIT_TENTH:  sel = 2'd1;
      EDIT_SEC:    sel = 2'd2;
      EDIT_TENSEC: sel = 2'd3;
      default:     sel = 2'd0;
    endcase
    return sel;
  endfunction

  // ======================================================================
  // Next mode
  // ======================================================================

  always_comb begin
    mode_d = mode_q;
    case (mode_q)
      IDLE: begin
        if (buttons_i.start_stop) begin
          mode_d = RUN;
        end else if (buttons_i.set) begin
          mode_d = EDIT_HUND;
        end
      end
      EDIT_HUND:   if (buttons_i.set) mode_d = EDIT_TENTH;
      EDIT_TENTH:  if (buttons_i.set) mode_d = EDIT_SEC;
      EDIT_SEC:    if (buttons_i.set) mode_d = EDIT_TENSEC;
      EDIT_TENSEC: if (buttons_i.set) mode_d = IDLE;
      RUN:         if (buttons_i.start_stop) mode_d = IDLE;
      default:     mode_d = IDLE;
    endcase
  end

  // Change only counts in the edit modes
  always_comb begin
    edit_d.sel = mode_digit(mode_q);
    edit_d.inc = 1'b0;
    case (mode_q)
      EDIT_HUND, EDIT_TENTH, EDIT_SEC, EDIT_TENSEC: edit_d.inc = buttons_i.change;
      default:                                      edit_d.inc = 1'b0;
    endcase
  end

  // ======================================================================
  // Registers
  // ======================================================================

  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      mode_q    <= IDLE;
      running_q <= 1'b0;
      edit_q    <= '0;
    end else begin
      mode_q    <= mode_d;
      running_q <= (mode_d == RUN);
      edit_q    <= edit_d;
    end
  end

  assign running_o = running_q;
  assign edit_o    = edit_q;

  // Counter must never see an edit on top of a tick
  a_no_edit_while_running : assert property (
    @(posedge clk100_i) disable iff (!rstn_i)
    edit_o.inc |-> !running_o
  );

endmodule

//--- verilog/time_counter.sv
`timescale 1ns/10ps

module time_counter
  import stopwatch_pkg::*;
(
  input  logic      clk100_i,
  input  logic      rstn_i,
  input  logic      running_i,
  input  edit_cmd_t edit_i,
  output time_t     time_o
);

  tick_cnt_t tick_cnt_q;
  logic      tick;
  time_t     time_q;
  digit_t    cur [4];
  logic      carry;
  logic [3:0] adv;

  // Next value of a digit, 9 rolls over to 0
  function automatic digit_t digit_next(digit_t d);
    digit_t n;
    if (d == digit_t'(DIGIT_MAX)) begin
      n = '0;
    end else begin
      n = d + 1'b1;
    end
    return n;
  endfunction

  // ======================================================================
  // Prescaler
  // ======================================================================

  assign tick = running_i && (tick_cnt_q == tick_cnt_t'(TICK_DIVIDE - 1));

  // Residue is held while stopped
  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      tick_cnt_q <= '0;
    end else if (tick) begin
      tick_cnt_q <= '0;
    end else if (running_i) begin
      tick_cnt_q <= tick_cnt_q + 1'b1;
    end
  end

  // ======================================================================
  // Digit cascade
  // ======================================================================

  assign cur[0] = time_q.hundredth;
  assign cur[1] = time_q.tenth;
  assign cur[2] = time_q.sec;
  assign cur[3] = time_q.ten_sec;

  // Tick ripples upward through digits at 9, edits stay local
  always_comb begin
    carry = tick;
    for (int i = 0; i < 4; i++) begin
      adv[i] = carry || (edit_i.inc && edit_i.sel == digit_sel_t'(i));
      carry  = carry && (cur[i] == digit_t'(DIGIT_MAX));
    end
  end

  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      time_q <= '0;
    end else begin
      if (adv[0]) begin
        time_q.hundredth <= digit_next(time_q.hundredth);
      end
      if (adv[1]) begin
        time_q.tenth <= digit_next(time_q.tenth);
      end
      if (adv[2]) begin
        time_q.sec <= digit_next(time_q.sec);
      end
      if (adv[3]) begin
        time_q.ten_sec <= digit_next(time_q.ten_sec);
      end
    end
  end

  assign time_o = time_q;

  // Every digit stays decimal
  a_digits_decimal : assert property (
    @(posedge clk100_i) disable iff (!rstn_i)
    (time_q.hundredth <= digit_t'(DIGIT_MAX)) &&
    (time_q.tenth     <= digit_t'(DIGIT_MAX)) &&
    (time_q.sec       <= digit_t'(DIGIT_MAX)) &&
    (time_q.ten_sec   <= digit_t'(DIGIT_MAX))
  );

endmodule

//--- verilog/seven_seg_decoder.sv
`timescale 1ns/10ps

module seven_seg_decoder
  import stopwatch_pkg::*, panel_pkg::*;
(
  input  digit_t digit_i,
  output seg_t   seg_o
);

  // Patterns are gfedcba, low lights a segment
  always_comb begin
    case (digit_i)
      4'd0:    seg_o = 7'b100_0000;
      4'd1:    seg_o = 7'b111_1001;
      4'd2:    seg_o = 7'b010_0100;
      4'd3:    seg_o = 7'b011_0000;
      4'd4:    seg_o = 7'b001_1001;
      4'd5:    seg_o = 7'b001_0010;
      4'd6:    seg_o = 7'b000_0010;
      4'd7:    seg_o = 7'b111_1000;
      4'd8:    seg_o = 7'b000_0000;
      4'd9:    seg_o = 7'b001_0000;
      // Dash for codes above nine
      default: seg_o = 7'b011_1111;
    endcase
  end

endmodule

//--- verilog/stopwatch_top.sv
`timescale 1ns/10ps

module stopwatch_top
  import stopwatch_pkg::*, panel_pkg::*;
(
  input  logic     clk100_i,
  input  logic     rstn_i,
  input  logic     start_stop_i,
  input  logic     set_i,
  input  logic     change_i,
  output display_t display_o
);

  buttons_t  buttons;
  logic      running;
  edit_cmd_t edit;
  time_t     time_val;

  // ======================================================================
  // Button conditioning, all three active low
  // ======================================================================

  button_debouncer i_start_stop_db (
    .clk100_i  (clk100_i),
    .rstn_i    (rstn_i),
    .button_i  (start_stop_i),
    .pressed_o (buttons.start_stop)
  );

  button_debouncer i_set_db (
    .clk100_i  (clk100_i),
    .rstn_i    (rstn_i),
    .button_i  (set_i),
    .pressed_o (buttons.set)
  );

  button_debouncer i_change_db (
    .clk100_i  (clk100_i),
    .rstn_i    (rstn_i),
    .button_i  (change_i),
    .pressed_o (buttons.change)
  );

  // ======================================================================
  // Mode control and timekeeping
  // ======================================================================

  stopwatch_control i_control (
    .clk100_i  (clk100_i),
    .rstn_i    (rstn_i),
    .buttons_i (buttons),
    .running_o (running),
    .edit_o    (edit)
  );

  time_counter i_counter (
    .clk100_i  (clk100_i),
    .rstn_i    (rstn_i),
    .running_i (running),
    .edit_i    (edit),
    .time_o    (time_val)
  );

  // Leftmost display is tens of seconds
  seven_seg_decoder i_dec3 (
    .digit_i (time_val.ten_sec),
    .seg_o   (display_o.hex3)
  );

  seven_seg_decoder i_dec2 (
    .digit_i (time_val.sec),
    .seg_o   (display_o.hex2)
  );

  seven_seg_decoder i_dec1 (
    .digit_i (time_val.tenth),
    .seg_o   (display_o.hex1)
  );

  seven_seg_decoder i_dec0 (
    .digit_i (time_val.hundredth),
    .seg_o   (display_o.hex0)
  );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rstn_o
);

  localparam int PERIOD_NS    = 40;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge
  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rstn_o <= 1'b1;
  end

endmodule

//--- tests/stopwatch_tb.sv
`timescale 1ns/10ps

module stopwatch_tb
  import stopwatch_pkg::*, panel_pkg::*;
();

  localparam int PRESS_LEN    = SYNC_STAGES + DEBOUNCE_CYCLES + 2;
  localparam int RESET_CYCLES = 16;
  localparam logic [31:0] LFSR_SEED = 32'h0cd3_88a0;

  typedef enum int {BTN_NONE, BTN_START, BTN_SET, BTN_CHANGE} btn_e;

  // One row of the stimulus table
  typedef struct {
    string name;
    btn_e  btn;
    int    count;
    int    hold;
    int    rel_len;
    int    wait_len;
    int    rand_bits;
  } step_t;

  logic        clk;
  logic        rstn;
  logic        start_stop;
  logic        set_btn;
  logic        change_btn;
  display_t    display;
  step_t       steps[$];
  mode_e       model_mode;
  time_t       model_time;
  int          model_residue;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;

  tb_clock_gen i_clk_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  stopwatch_top i_dut (
    .clk100_i     (clk),
    .rstn_i       (rstn),
    .start_stop_i (start_stop),
    .set_i        (set_btn),
    .change_i     (change_btn),
    .display_o    (display)
  );

  // ======================================================================
  // Reference model
  // ======================================================================

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic digit_t bump_digit(digit_t d);
    return digit_t'((int'(d) + 1) % (DIGIT_MAX + 1));
  endfunction

  // Time kept as whole hundredths, wrapping at 100 s
  function automatic time_t add_centis(time_t t, int n);
    int    v;
    time_t r;
    v = int'(t.ten_sec) * 1000 + int'(t.sec) * 100 + int'(t.tenth) * 10 + int'(t.hundredth);
    v = (v + n) % 10000;
    r.ten_sec   = digit_t'(v / 1000);
    r.sec       = digit_t'((v / 100) % 10);
    r.tenth     = digit_t'((v / 10) % 10);
    r.hundredth = digit_t'(v % 10);
    return r;
  endfunction

  // gfedcba, low is lit
  function automatic seg_t digit_seg(digit_t d);
    case (d)
      4'd0:    return 7'h40;
      4'd1:    return 7'h79;
      4'd2:    return 7'h24;
      4'd3:    return 7'h30;
      4'd4:    return 7'h19;
      4'd5:    return 7'h12;
      4'd6:    return 7'h02;
      4'd7:    return 7'h78;
      4'd8:    return 7'h00;
      4'd9:    return 7'h10;
      default: return 7'h3f;
    endcase
  endfunction

  function automatic display_t expected_display(time_t t);
    return {digit_seg(t.ten_sec), digit_seg(t.sec), digit_seg(t.tenth), digit_seg(t.hundredth)};
  endfunction

  function automatic int step_len(int idx);
    return steps[idx].count * (steps[idx].hold + steps[idx].rel_len) + steps[idx].wait_len + 1;
  endfunction

  task automatic model_press(input btn_e b);
    if (model_mode == RUN) begin
      if (b == BTN_START) model_mode = IDLE;
    end else if (model_mode == IDLE) begin
      if (b == BTN_START) model_mode = RUN;
      else if (b == BTN_SET) model_mode = EDIT_HUND;
    end else if (b == BTN_SET) begin
      case (model_mode)
        EDIT_HUND:  model_mode = EDIT_TENTH;
        EDIT_TENTH: model_mode = EDIT_SEC;
        EDIT_SEC:   model_mode = EDIT_TENSEC;
        default:    model_mode = IDLE;
      endcase
    end else if (b == BTN_CHANGE) begin
      case (model_mode)
        EDIT_HUND:  model_time.hundredth = bump_digit(model_time.hundredth);
        EDIT_TENTH: model_time.tenth = bump_digit(model_time.tenth);
        EDIT_SEC:   model_time.sec = bump_digit(model_time.sec);
        default:    model_time.ten_sec = bump_digit(model_time.ten_sec);
      endcase
    end
  endtask

  // ======================================================================
  // Stimulus and checks
  // ======================================================================

  task automatic add_step(input string name, input btn_e btn, input int count,
                          input int hold, input int rel_len, input int wait_len,
                          input int rand_bits);
    step_t s;
    s = '{name, btn, count, hold, rel_len, wait_len, rand_bits};
    steps.push_back(s);
  endtask

  task automatic drive_button(input btn_e b, input logic level);
    case (b)
      BTN_START:  start_stop <= level;
      BTN_SET:    set_btn <= level;
      BTN_CHANGE: change_btn <= level;
      default:    ;
    endcase
  endtask

  task automatic check_display(input string name, input display_t exp, input display_t act);
    if (act !== exp) begin
      $display("Error: %s display expected %h actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1, "Display mismatch");
    end
  endtask

  task automatic check_time(input string name, input time_t exp, input time_t act);
    if (act !== exp) begin
      $display("Error: %s time expected %h actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1, "Time mismatch");
    end
  endtask

  // Starts just after a rising edge, ends at a falling edge
  task automatic run_step(input int idx);
    for (int n = 0; n < steps[idx].count; n++) begin
      drive_button(steps[idx].btn, 1'b0);
      repeat (steps[idx].hold) @(posedge clk);
      drive_button(steps[idx].btn, 1'b1);
      repeat (steps[idx].rel_len) @(posedge clk);
    end
    repeat (steps[idx].wait_len) @(posedge clk);
    @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: run went past %0d cycles", cycle_limit);
      $display("Test failures found");
      $fatal(1, "Simulation timed out");
    end
  end

  initial begin
    logic [31:0] lfsr;
    int          extra;
    int          total;
    start_stop    = 1'b1;
    set_btn       = 1'b1;
    change_btn    = 1'b1;
    cycle_cnt     = 0;
    model_mode    = IDLE;
    model_time    = '0;
    model_residue = 0;

    add_step("reset_display",  BTN_NONE,   0, PRESS_LEN, PRESS_LEN, 20, 0);
    add_step("change_in_idle", BTN_CHANGE, 1, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("enter_edit",     BTN_SET,    1, PRESS_LEN, PRESS_LEN + 1, 0, 0);
    add_step("hund_plus3",     BTN_CHANGE, 3, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("to_tenth",       BTN_SET,    1, PRESS_LEN + 2, PRESS_LEN, 0, 0);
    add_step("tenth_wrap",     BTN_CHANGE, 11, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("to_sec",         BTN_SET,    1, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("sec_plus5",      BTN_CHANGE, 5, PRESS_LEN, PRESS_LEN + 3, 0, 0);
    add_step("to_tensec",      BTN_SET,    1, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("tensec_wrap",    BTN_CHANGE, 10, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("tensec_plus2",   BTN_CHANGE, 2, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("back_to_idle",   BTN_SET,    1, PRESS_LEN, PRESS_LEN, 5, 0);
    // Walk up to 99.93 for the wrap run
    add_step("edit_to_tenth",  BTN_SET,    2, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("tenth_to_9",     BTN_CHANGE, 8, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("edit_to_sec",    BTN_SET,    1, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("sec_to_9",       BTN_CHANGE, 4, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("edit_to_tensec", BTN_SET,    1, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("tensec_to_9",    BTN_CHANGE, 7, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("edit_done",      BTN_SET,    1, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("wrap_start",     BTN_START,  1, PRESS_LEN, PRESS_LEN, 40, 0);
    add_step("wrap_stop",      BTN_START,  1, PRESS_LEN, PRESS_LEN, 0, 0);
    add_step("rand_start",     BTN_START,  1, PRESS_LEN, PRESS_LEN, 300, 10);
    add_step("rand_stop",      BTN_START,  1, PRESS_LEN, PRESS_LEN + 1, 0, 0);
    add_step("resume_start",   BTN_START,  1, PRESS_LEN, PRESS_LEN, 100, 8);
    add_step("set_in_run",     BTN_SET,    1, PRESS_LEN, PRESS_LEN, 20, 0);
    add_step("resume_stop",    BTN_START,  1, PRESS_LEN, PRESS_LEN, 0, 0);

    // Random run lengths, one LFSR step per bit
    lfsr        = LFSR_SEED;
    cycle_limit = RESET_CYCLES + 200;
    foreach (steps[i]) begin
      extra = 0;
      for (int b = 0; b < steps[i].rand_bits; b++) begin
        lfsr  = lfsr_next(lfsr);
        extra = (extra << 1) | int'(lfsr[0]);
      end
      steps[i].wait_len += extra;
      cycle_limit += step_len(i);
    end

    @(posedge rstn);
    @(posedge clk);
    foreach (steps[i]) begin
      run_step(i);
      for (int n = 0; n < steps[i].count; n++) begin
        model_press(steps[i].btn);
      end
      if (model_mode == RUN) begin
        total         = model_residue + step_len(i);
        model_time    = add_centis(model_time, total / TICK_DIVIDE);
        model_residue = total % TICK_DIVIDE;
      end else begin
        check_time(steps[i].name, model_time, i_dut.time_val);
        check_display(steps[i].name, expected_display(model_time), display);
      end
      @(posedge clk);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- tb.f
verilog/stopwatch_pkg.sv
verilog/panel_pkg.sv
verilog/button_debouncer.sv
verilog/stopwatch_control.sv
verilog/time_counter.sv
verilog/seven_seg_decoder.sv
verilog/stopwatch_top.sv
tests/tb_clock_gen.sv
tests/stopwatch_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        := stopwatch_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
